//--- logic/mcu_mbox_config.svh
/*
 * Build-time sizes, user attributes and register map of the mailbox.
 * Included by the bus package and by the RTL that decodes addresses
 * or compares users against the default valid user.
 */
`ifndef MCU_MBOX_CONFIG_SVH
`define MCU_MBOX_CONFIG_SVH

// SRAM geometry, one 32-bit word per entry
`define MBOX_SRAM_SIZE_BYTES 4096
`define MBOX_DATA_W 32
`define MBOX_SRAM_ADDR_W 10

// Request bus widths, address is a byte address
`define MBOX_ADDR_W 16
`define MBOX_USER_W 32

// Programmable valid users plus the always-valid default user
`define MBOX_NUM_VALID_USERS 5
`define MBOX_DEF_VALID_USER 32'hFFFF_FFFF

// Register offsets
`define MBOX_LOCK_OFS 16'h0000
`define MBOX_USER_OFS 16'h0004
`define MBOX_DLEN_OFS 16'h0008
`define MBOX_EXECUTE_OFS 16'h000C

// SRAM window, 8 KB of bus space of which only the SRAM size is backed
`define MBOX_SRAM_BASE 16'h1000
`define MBOX_SRAM_WIN_BYTES 16'h2000

`endif

//--- logic/mcu_mbox_bus_pkg.sv
/*
 * Types carried on the mailbox request bus and the external SRAM port.
 * Widths come from the config header.
 */
`include "mcu_mbox_config.svh"

package mcu_mbox_bus_pkg;

    // User attribute of a request
    typedef logic [`MBOX_USER_W-1:0] mbox_user_t;

    // Byte address on the request bus
    typedef logic [`MBOX_ADDR_W-1:0] mbox_addr_t;

    // Data word, same width on the bus and in the SRAM
    typedef logic [`MBOX_DATA_W-1:0] mbox_data_t;

    // SRAM word address
    typedef logic [`MBOX_SRAM_ADDR_W-1:0] mbox_sram_addr_t;

    // Data length in bytes, a full register word
    typedef logic [`MBOX_DATA_W-1:0] mbox_dlen_t;

    // Strapped list of programmable valid users
    typedef mbox_user_t [`MBOX_NUM_VALID_USERS-1:0] mbox_user_list_t;

endpackage

//--- logic/mcu_mbox_ctrl_pkg.sv
/*
 * Encodings used inside the mailbox control path.
 * Register select is the decoded target of one bus request; the zero
 * state is the SRAM clearing machine.
 */
package mcu_mbox_ctrl_pkg;

    // Decoded request target
    typedef enum logic [2:0] {
        NONE,
        LOCK,
        USER,
        DLEN,
        EXECUTE,
        SRAM
    } mbox_reg_sel_e;

    // SRAM zeroization
    // DONE carries the last zero write
    typedef enum logic [1:0] {
        IDLE,
        ZEROING,
        DONE
    } mbox_zero_state_e;

endpackage

//--- logic/mcu_mbox_user_check.sv
/*
 * Classifies the user of the current request against the valid list,
 * the default user, the strapped root user and the lock holder.
 * Purely combinational, every output qualified with req.
 */
`timescale 1ns/1ps
`include "mcu_mbox_config.svh"

module mcu_mbox_user_check (
    input  logic                              req,
    input  mcu_mbox_bus_pkg::mbox_user_t      req_user,
    input  mcu_mbox_bus_pkg::mbox_user_list_t valid_users,
    input  mcu_mbox_bus_pkg::mbox_user_t      strap_root_user,
    input  mcu_mbox_bus_pkg::mbox_user_t      lock_user,
    output logic                              user_valid,
    output logic                              user_is_root,
    output logic                              user_is_requester
);

    logic list_match;
    logic def_match;
    logic root_match;
    logic lock_match;

    // Any of the programmable users
    always_comb begin
        list_match = 1'b0;
        for (int i = 0; i < `MBOX_NUM_VALID_USERS; i++) begin
            list_match |= (req_user == valid_users[i]);
        end
    end

    // Default user is always valid
    assign def_match  = (req_user == `MBOX_DEF_VALID_USER);
    assign root_match = (req_user == strap_root_user);
    // Holder match alone, the control path adds the lock state
    assign lock_match = (req_user == lock_user);

    assign user_valid        = req & (list_match | def_match | root_match);
    assign user_is_root      = req & root_match;
    assign user_is_requester = req & lock_match;

    // Holder is only ever recorded from a valid request, zero means released
    always_comb begin
        if (user_is_requester && (lock_user != '0)) begin
            assert (user_valid)
            else $error("lock holder matched but user is not valid");
        end
    end

endmodule

//--- logic/mcu_mbox_zeroizer.sv
/*
 * Clears the SRAM after a mailbox release, one word per cycle from word 0
 * up to the end word. Owns the external SRAM port: zero writes while busy,
 * otherwise the gated access from the control module goes straight through.
 */
`timescale 1ns/1ps

module mcu_mbox_zeroizer (
    input  logic                              clk,
    input  logic                              rst_b,
    input  logic                              mbox_release,
    input  mcu_mbox_bus_pkg::mbox_sram_addr_t zero_end_addr,
    input  logic                              acc_cs,
    input  logic                              acc_we,
    input  mcu_mbox_bus_pkg::mbox_sram_addr_t acc_addr,
    input  mcu_mbox_bus_pkg::mbox_data_t      acc_wdata,
    output logic                              sram_cs,
    output logic                              sram_we,
    output mcu_mbox_bus_pkg::mbox_sram_addr_t sram_addr,
    output mcu_mbox_bus_pkg::mbox_data_t      sram_wdata,
    output logic                              zero_busy,
    output logic                              zero_done
);

    mcu_mbox_ctrl_pkg::mbox_zero_state_e state_q;
    mcu_mbox_bus_pkg::mbox_sram_addr_t   zero_addr_q;
    mcu_mbox_bus_pkg::mbox_sram_addr_t   zero_addr_inc;

    assign zero_addr_inc = zero_addr_q + 1'b1;

    ////////////////////////////////////////////////////////////////////////
    // Zeroing FSM

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state_q     <= mcu_mbox_ctrl_pkg::IDLE;
            zero_addr_q <= '0;
        end else begin
            case (state_q)
                mcu_mbox_ctrl_pkg::IDLE: begin
                    // Single word to clear goes straight to the last write
                    if (mbox_release) begin
                        zero_addr_q <= '0;
                        state_q     <= (zero_end_addr == '0) ? mcu_mbox_ctrl_pkg::DONE
                                                             : mcu_mbox_ctrl_pkg::ZEROING;
                    end
                end
                mcu_mbox_ctrl_pkg::ZEROING: begin
                    zero_addr_q <= zero_addr_inc;
                    if (zero_addr_inc == zero_end_addr) begin
                        state_q <= mcu_mbox_ctrl_pkg::DONE;
                    end
                end
                mcu_mbox_ctrl_pkg::DONE: begin
                    state_q <= mcu_mbox_ctrl_pkg::IDLE;
                end
                default: begin
                    state_q <= mcu_mbox_ctrl_pkg::IDLE;
                end
            endcase
        end
    end

    assign zero_busy = (state_q != mcu_mbox_ctrl_pkg::IDLE);
    // Pulses together with the last zero write
    assign zero_done = (state_q == mcu_mbox_ctrl_pkg::DONE);

    ////////////////////////////////////////////////////////////////////////
    // SRAM port mux

    assign sram_cs    = zero_busy | acc_cs;
    assign sram_we    = zero_busy | acc_we;
    assign sram_addr  = zero_busy ? zero_addr_q : acc_addr;
    assign sram_wdata = zero_busy ? '0 : acc_wdata;

    // Control blocks execute writes while zeroing, so no second release
    assert property (@(posedge clk) disable iff (!rst_b) mbox_release |-> !zero_busy)
    else $error("release while zeroing");

    // End word is held stable for the whole clear
    assert property (@(posedge clk) disable iff (!rst_b)
        zero_busy |-> (zero_addr_q <= zero_end_addr))
    else $error("zero address passed end word");

endmodule

//--- logic/mcu_mbox_ctrl.sv
/*
 * Mailbox register file and lock control. Decodes each request, gates
 * register and SRAM access to the lock holder or the root user, issues the
 * release to the zeroizer and returns read data one cycle after the request.
 */
`timescale 1ns/1ps
`include "mcu_mbox_config.svh"

module mcu_mbox_ctrl (
    input  logic                              clk,
    input  logic                              rst_b,
    input  logic                              req,
    input  logic                              req_write,
    input  mcu_mbox_bus_pkg::mbox_addr_t      req_addr,
    input  mcu_mbox_bus_pkg::mbox_data_t      req_wdata,
    input  mcu_mbox_bus_pkg::mbox_user_t      req_user,
    input  mcu_mbox_bus_pkg::mbox_user_t      strap_root_user,
    input  logic                              user_valid,
    input  logic                              user_is_root,
    input  logic                              user_is_requester,
    input  logic                              zero_busy,
    input  logic                              zero_done,
    input  mcu_mbox_bus_pkg::mbox_data_t      sram_rdata,
    output mcu_mbox_bus_pkg::mbox_user_t      lock_user,
    output logic                              mbox_release,
    output mcu_mbox_bus_pkg::mbox_sram_addr_t zero_end_addr,
    output logic                              acc_cs,
    output logic                              acc_we,
    output mcu_mbox_bus_pkg::mbox_sram_addr_t acc_addr,
    output mcu_mbox_bus_pkg::mbox_data_t      acc_wdata,
    output logic                              resp_error,
    output logic                              resp_rd_valid,
    output mcu_mbox_bus_pkg::mbox_data_t      resp_rdata,
    output logic                              root_data_available,
    output logic                              soc_data_available,
    output logic                              soc_req_locked
);

    mcu_mbox_ctrl_pkg::mbox_reg_sel_e sel;
    mcu_mbox_bus_pkg::mbox_addr_t     win_ofs;
    mcu_mbox_bus_pkg::mbox_dlen_t     dlen_q;
    mcu_mbox_bus_pkg::mbox_dlen_t     max_dlen_q;
    mcu_mbox_bus_pkg::mbox_dlen_t     max_dlen;
    mcu_mbox_bus_pkg::mbox_dlen_t     end_bytes;
    mcu_mbox_bus_pkg::mbox_data_t     reg_rdata;
    mcu_mbox_bus_pkg::mbox_data_t     reg_rdata_q;
    logic lock_q;
    logic lock_init_q;
    logic execute_q;
    logic lock_eff;
    logic valid_req;
    logic acc_ok;
    logic lock_rd;
    logic sram_ok;
    logic sram_rd_q;

    ////////////////////////////////////////////////////////////////////////
    // Request decode

    assign win_ofs = req_addr - `MBOX_SRAM_BASE;

    always_comb begin
        sel = mcu_mbox_ctrl_pkg::NONE;
        if ((req_addr >= `MBOX_SRAM_BASE) &&
            (req_addr < (`MBOX_SRAM_BASE + `MBOX_SRAM_WIN_BYTES))) begin
            sel = mcu_mbox_ctrl_pkg::SRAM;
        end else begin
            case (req_addr)
                `MBOX_LOCK_OFS:    sel = mcu_mbox_ctrl_pkg::LOCK;
                `MBOX_USER_OFS:    sel = mcu_mbox_ctrl_pkg::USER;
                `MBOX_DLEN_OFS:    sel = mcu_mbox_ctrl_pkg::DLEN;
                `MBOX_EXECUTE_OFS: sel = mcu_mbox_ctrl_pkg::EXECUTE;
                default:           sel = mcu_mbox_ctrl_pkg::NONE;
            endcase
        end
    end

    // Invalid users get an error and touch nothing
    assign valid_req  = req & user_valid;
    assign resp_error = req & !user_valid;

    // Lock stays set while clearing but grants nothing
    assign lock_eff = lock_q & !zero_busy;
    assign acc_ok   = valid_req & lock_eff & (user_is_requester | user_is_root);
    assign lock_rd  = valid_req & !req_write & (sel == mcu_mbox_ctrl_pkg::LOCK);

    // Release on execute written to 0
    assign mbox_release = acc_ok & req_write & (sel == mcu_mbox_ctrl_pkg::EXECUTE) &
                          !req_wdata[0];

    ////////////////////////////////////////////////////////////////////////
    // Lock, holder, dlen and execute

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            lock_init_q <= 1'b1;
            lock_q      <= 1'b1;
            lock_user   <= '0;
            dlen_q      <= '0;
            execute_q   <= 1'b0;
        end else begin
            lock_init_q <= 1'b0;
            // Lock only drops once the SRAM is clean
            if (zero_done) begin
                lock_q <= 1'b0;
            end else if (lock_rd && !lock_q) begin
                lock_q <= 1'b1;
            end
            // Root owns the mailbox out of reset
            if (lock_init_q) begin
                lock_user <= strap_root_user;
            end else if (mbox_release) begin
                lock_user <= '0;
            end else if (lock_rd && !lock_q) begin
                lock_user <= req_user;
            end
            if (mbox_release) begin
                dlen_q    <= '0;
                execute_q <= 1'b0;
            end else if (acc_ok && req_write) begin
                if (sel == mcu_mbox_ctrl_pkg::DLEN) begin
                    dlen_q <= req_wdata;
                end
                if (sel == mcu_mbox_ctrl_pkg::EXECUTE) begin
                    execute_q <= req_wdata[0];
                end
            end
        end
    end

    // Largest dlen seen during this lock, current dlen included
    assign max_dlen = (dlen_q > max_dlen_q) ? dlen_q : max_dlen_q;

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            max_dlen_q <= '0;
        end else if (zero_done) begin
            max_dlen_q <= '0;
        end else begin
            max_dlen_q <= max_dlen;
        end
    end

    // Last byte to clear, as a word address
    assign end_bytes     = max_dlen - 1'b1;
    assign zero_end_addr = end_bytes[`MBOX_SRAM_ADDR_W+1:2];

    ////////////////////////////////////////////////////////////////////////
    // SRAM access gating

    assign sram_ok   = acc_ok & (sel == mcu_mbox_ctrl_pkg::SRAM) &
                       (win_ofs < `MBOX_SRAM_SIZE_BYTES);
    assign acc_cs    = sram_ok;
    assign acc_we    = sram_ok & req_write;
    assign acc_addr  = sram_ok ? win_ofs[`MBOX_SRAM_ADDR_W+1:2] : '0;
    assign acc_wdata = sram_ok ? req_wdata : '0;

    ////////////////////////////////////////////////////////////////////////
    // Read return

    // Lock and holder are open to any valid user
    always_comb begin
        case (sel)
            mcu_mbox_ctrl_pkg::LOCK:    reg_rdata = mcu_mbox_bus_pkg::mbox_data_t'(lock_q);
            mcu_mbox_ctrl_pkg::USER:    reg_rdata = lock_user;
            mcu_mbox_ctrl_pkg::DLEN:    reg_rdata = acc_ok ? dlen_q : '0;
            mcu_mbox_ctrl_pkg::EXECUTE: reg_rdata = acc_ok ?
                mcu_mbox_bus_pkg::mbox_data_t'(execute_q) : '0;
            default:                    reg_rdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            resp_rd_valid <= 1'b0;
            sram_rd_q     <= 1'b0;
        end else begin
            resp_rd_valid <= valid_req & !req_write;
            sram_rd_q     <= sram_ok & !req_write;
        end
    end

    // Register value as it was before this request's own update
    always_ff @(posedge clk) begin
        reg_rdata_q <= reg_rdata;
    end

    assign resp_rdata = sram_rd_q ? sram_rdata : reg_rdata_q;

    ////////////////////////////////////////////////////////////////////////
    // Status

    assign root_data_available = execute_q & (lock_user == strap_root_user);
    assign soc_data_available  = execute_q & (lock_user != strap_root_user);
    // SoC knocking while root holds the lock
    assign soc_req_locked = lock_rd & lock_eff & (lock_user == strap_root_user) &
                            !user_is_root;

    // Zeroizer takes up every release on the next cycle
    assert property (@(posedge clk) disable iff (!rst_b)
        mbox_release |=> zero_busy)
    else $error("release not taken up by the zeroizer");

endmodule

//--- logic/mcu_mbox_top.sv
/*
 * Mailbox top level: user checker and zeroizer side by side, combined
 * by the control module. Connects the request bus, the external SRAM,
 * the user straps and the status outputs.
 */
`timescale 1ns/1ps

module mcu_mbox_top (
    input  logic                              clk,
    input  logic                              rst_b,
    // Request bus
    input  logic                              req,
    input  logic                              req_write,
    input  mcu_mbox_bus_pkg::mbox_addr_t      req_addr,
    input  mcu_mbox_bus_pkg::mbox_data_t      req_wdata,
    input  mcu_mbox_bus_pkg::mbox_user_t      req_user,
    output logic                              resp_error,
    output mcu_mbox_bus_pkg::mbox_data_t      resp_rdata,
    output logic                              resp_rd_valid,
    // External SRAM
    output logic                              sram_cs,
    output logic                              sram_we,
    output mcu_mbox_bus_pkg::mbox_sram_addr_t sram_addr,
    output mcu_mbox_bus_pkg::mbox_data_t      sram_wdata,
    input  mcu_mbox_bus_pkg::mbox_data_t      sram_rdata,
    // Straps
    input  mcu_mbox_bus_pkg::mbox_user_t      strap_root_user,
    input  mcu_mbox_bus_pkg::mbox_user_list_t valid_users,
    // Status
    output logic                              root_data_available,
    output logic                              soc_data_available,
    output logic                              soc_req_locked
);

    logic                              user_valid;
    logic                              user_is_root;
    logic                              user_is_requester;
    mcu_mbox_bus_pkg::mbox_user_t      lock_user;
    logic                              mbox_release;
    mcu_mbox_bus_pkg::mbox_sram_addr_t zero_end_addr;
    logic                              acc_cs;
    logic                              acc_we;
    mcu_mbox_bus_pkg::mbox_sram_addr_t acc_addr;
    mcu_mbox_bus_pkg::mbox_data_t      acc_wdata;
    logic                              zero_busy;
    logic                              zero_done;

    mcu_mbox_user_check u_user_check (
        .req               (req),
        .req_user          (req_user),
        .valid_users       (valid_users),
        .strap_root_user   (strap_root_user),
        .lock_user         (lock_user),
        .user_valid        (user_valid),
        .user_is_root      (user_is_root),
        .user_is_requester (user_is_requester)
    );

    mcu_mbox_zeroizer u_zeroizer (
        .clk           (clk),
        .rst_b         (rst_b),
        .mbox_release  (mbox_release),
        .zero_end_addr (zero_end_addr),
        .acc_cs        (acc_cs),
        .acc_we        (acc_we),
        .acc_addr      (acc_addr),
        .acc_wdata     (acc_wdata),
        .sram_cs       (sram_cs),
        .sram_we       (sram_we),
        .sram_addr     (sram_addr),
        .sram_wdata    (sram_wdata),
        .zero_busy     (zero_busy),
        .zero_done     (zero_done)
    );

    mcu_mbox_ctrl u_ctrl (
        .clk                 (clk),
        .rst_b               (rst_b),
        .req                 (req),
        .req_write           (req_write),
        .req_addr            (req_addr),
        .req_wdata           (req_wdata),
        .req_user            (req_user),
        .strap_root_user     (strap_root_user),
        .user_valid          (user_valid),
        .user_is_root        (user_is_root),
        .user_is_requester   (user_is_requester),
        .zero_busy           (zero_busy),
        .zero_done           (zero_done),
        .sram_rdata          (sram_rdata),
        .lock_user           (lock_user),
        .mbox_release        (mbox_release),
        .zero_end_addr       (zero_end_addr),
        .acc_cs              (acc_cs),
        .acc_we              (acc_we),
        .acc_addr            (acc_addr),
        .acc_wdata           (acc_wdata),
        .resp_error          (resp_error),
        .resp_rd_valid       (resp_rd_valid),
        .resp_rdata          (resp_rdata),
        .root_data_available (root_data_available),
        .soc_data_available  (soc_data_available),
        .soc_req_locked      (soc_req_locked)
    );

endmodule

//--- dv/mcu_mbox_tb.sv
/*
 * Testbench for the mailbox top level. Drives random bus traffic from a
 * fixed seed, models the SRAM behind the DUT and predicts every response
 * and status output cycle by cycle with a reference model.
 */
`timescale 1ns/1ps
`include "mcu_mbox_config.svh"

module mcu_mbox_tb;

    localparam logic [31:0] ROOT   = 32'h0000_0A5A;
    localparam logic [31:0] USER_A = 32'h1000_0001;
    localparam logic [31:0] USER_B = 32'h1000_0002;
    localparam logic [31:0] USER_C = 32'h1000_0003;
    localparam int          MAX_CYCLES = 20000;

    logic        clk;
    logic        rst_b;
    logic        req;
    logic        req_write;
    logic [15:0] req_addr;
    logic [31:0] req_wdata;
    logic [31:0] req_user;
    logic        resp_error;
    logic [31:0] resp_rdata;
    logic        resp_rd_valid;
    logic        sram_cs;
    logic        sram_we;
    logic [9:0]  sram_addr;
    logic [31:0] sram_wdata;
    logic [31:0] sram_rdata;
    logic [31:0] strap_root_user;
    mcu_mbox_bus_pkg::mbox_user_list_t valid_users;
    logic        root_data_available;
    logic        soc_data_available;
    logic        soc_req_locked;

    logic [31:0] sram_mem [1024];
    logic [31:0] shadow [1024];
    integer      seed;
    int          cycles;
    int          err_cnt;
    string       test_name;

    // Reference model state, always one edge ahead of the DUT registers
    logic        m_lock;
    logic        m_init;
    logic        m_exec;
    logic [31:0] m_user;
    logic [31:0] m_dlen;
    logic [31:0] m_maxd;
    logic        m_zbusy;
    logic [9:0]  m_zaddr;
    logic [9:0]  m_zend;
    logic        pend_v;
    logic [31:0] pend_d;

    mcu_mbox_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // External SRAM, read data one cycle after the strobe
    always @(posedge clk) begin
        if (sram_cs) begin
            if (sram_we) begin
                sram_mem[sram_addr] <= sram_wdata;
            end else begin
                sram_rdata <= sram_mem[sram_addr];
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("ERROR timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("tests failed");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic check(input string label, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            err_cnt++;
            $display("ERROR %s/%s expected %h actual %h", test_name, label, exp, act);
            $display("tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic user_ok(input logic [31:0] u);
        logic hit;
        hit = (u == `MBOX_DEF_VALID_USER) || (u == strap_root_user);
        for (int i = 0; i < `MBOX_NUM_VALID_USERS; i++) begin
            hit |= (u == valid_users[i]);
        end
        return hit;
    endfunction

    ////////////////////////////////////////////////////////////////////////
    // Reference model, one step per cycle at the falling edge

    task automatic model_step();
        logic        v;
        logic        le;
        logic        acc;
        logic        lrd;
        logic        rel;
        logic        sok;
        logic        zd;
        logic [15:0] ofs;
        logic [31:0] mx;
        int          sel;
        // Decode: 0 none, 1 lock, 2 user, 3 dlen, 4 execute, 5 window
        sel = 0;
        if (req_addr >= 16'h1000 && req_addr < 16'h3000) sel = 5;
        else if (req_addr == 16'h0000) sel = 1;
        else if (req_addr == 16'h0004) sel = 2;
        else if (req_addr == 16'h0008) sel = 3;
        else if (req_addr == 16'h000C) sel = 4;
        ofs = req_addr - 16'h1000;
        v   = req && user_ok(req_user);
        le  = m_lock && !m_zbusy;
        acc = v && le && (req_user == m_user || req_user == strap_root_user);
        lrd = v && !req_write && sel == 1;
        rel = acc && req_write && sel == 4 && !req_wdata[0];
        sok = acc && sel == 5 && ofs < 16'd4096;
        zd  = m_zbusy && (m_zaddr == m_zend);
        mx  = (m_dlen > m_maxd) ? m_dlen : m_maxd;

        check("resp_error", 32'(req && !v), 32'(resp_error));
        check("soc_req_locked", 32'(lrd && le && m_user == strap_root_user &&
              req_user != strap_root_user), 32'(soc_req_locked));
        check("root_data_available", 32'(m_exec && m_user == strap_root_user),
              32'(root_data_available));
        check("soc_data_available", 32'(m_exec && m_user != strap_root_user),
              32'(soc_data_available));
        check("resp_rd_valid", 32'(pend_v), 32'(resp_rd_valid));
        if (pend_v) begin
            check("resp_rdata", pend_d, resp_rdata);
        end

        // Read data for next cycle, register values before this update
        pend_v = v && !req_write;
        pend_d = '0;
        if (sok) pend_d = shadow[ofs[11:2]];
        else if (sel == 1) pend_d = 32'(m_lock);
        else if (sel == 2) pend_d = m_user;
        else if (sel == 3 && acc) pend_d = m_dlen;
        else if (sel == 4 && acc) pend_d = 32'(m_exec);

        // Zeroing walk, one word per cycle
        if (m_zbusy) begin
            shadow[m_zaddr] = '0;
            if (zd) m_zbusy = 1'b0;
            else m_zaddr = m_zaddr + 1'b1;
        end
        if (sok && req_write) shadow[ofs[11:2]] = req_wdata;

        if (m_init) m_user = strap_root_user;
        else if (rel) m_user = '0;
        else if (lrd && !m_lock) m_user = req_user;
        m_init = 1'b0;
        if (zd) m_lock = 1'b0;
        else if (lrd) m_lock = 1'b1;

        if (rel) begin
            m_dlen  = '0;
            m_exec  = 1'b0;
            m_zbusy = 1'b1;
            m_zaddr = '0;
            m_zend  = 10'((mx - 32'd1) >> 2);
        end else if (acc && req_write && sel == 3) begin
            m_dlen = req_wdata;
        end else if (acc && req_write && sel == 4) begin
            m_exec = req_wdata[0];
        end
        m_maxd = zd ? 32'd0 : mx;
    endtask

    always @(negedge clk) begin
        if (rst_b) model_step();
    end

    ////////////////////////////////////////////////////////////////////////
    // Bus driving

    task automatic issue(input logic w, input logic [15:0] a, input logic [31:0] d,
                         input logic [31:0] u);
        @(posedge clk);
        req       <= 1'b1;
        req_write <= w;
        req_addr  <= a;
        req_wdata <= d;
        req_user  <= u;
    endtask

    task automatic idle();
        @(posedge clk);
        req <= 1'b0;
    endtask

    function automatic logic [31:0] pick_user();
        int k;
        k = {$random(seed)} % 8;
        if (k < 5) return valid_users[k];
        if (k == 5) return ROOT;
        if (k == 6) return `MBOX_DEF_VALID_USER;
        return $random(seed);
    endfunction

    // Take the lock for u, releasing any other holder through the root
    task automatic acquire(input logic [31:0] u);
        idle();
        while (m_zbusy) idle();
        if (m_lock && m_user != u) begin
            issue(1'b1, `MBOX_EXECUTE_OFS, 32'd0, ROOT);
            idle();
            while (m_zbusy || m_lock) idle();
        end
        if (!m_lock) begin
            issue(1'b0, `MBOX_LOCK_OFS, 32'd0, u);
            idle();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Test sequences

    initial begin
        logic [15:0] a;
        logic [31:0] d;
        int          k;
        seed = 32'hdc16;
        cycles = 0;
        err_cnt = 0;
        test_name = "reset";
        rst_b = 1'b0;
        req = 1'b0;
        req_write = 1'b0;
        req_addr = '0;
        req_wdata = '0;
        req_user = '0;
        sram_rdata = '0;
        strap_root_user = ROOT;
        for (int i = 0; i < 5; i++) valid_users[i] = 32'h1000_0001 + i;
        // Fill depends on every address bit
        for (int i = 0; i < 1024; i++) begin
            sram_mem[i] = 32'hC0DE_0000 | (i * 32'h0000_0041);
            shadow[i]   = sram_mem[i];
        end
        m_lock = 1'b1;
        m_init = 1'b1;
        m_exec = 1'b0;
        m_user = '0;
        m_dlen = '0;
        m_maxd = '0;
        m_zbusy = 1'b0;
        m_zaddr = '0;
        m_zend = '0;
        pend_v = 1'b0;
        pend_d = '0;
        repeat (16) @(posedge clk);
        rst_b <= 1'b1;
        idle();
        idle();

        // Root owns the mailbox after reset
        test_name = "after_reset";
        issue(1'b0, `MBOX_LOCK_OFS, 32'd0, ROOT);
        issue(1'b0, `MBOX_USER_OFS, 32'd0, ROOT);
        idle();
        @(negedge clk);
        check("root_data_available", 32'd0, 32'(root_data_available));

        // Random traffic from valid and invalid users
        test_name = "random_users";
        for (int n = 0; n < 300; n++) begin
            k = {$random(seed)} % 6;
            a = (k == 5) ? 16'h1000 + (16'($random(seed)) & 16'h1FFC) : 16'(k * 4);
            d = (k == 5) ? $random(seed) : ($random(seed) & 32'hFF);
            issue(1'($random(seed)), a, d, pick_user());
            if ($random(seed) & 1) idle();
        end

        // Release by the root, then a new holder
        test_name = "lock_release";
        acquire(ROOT);
        issue(1'b1, `MBOX_DLEN_OFS, 32'd64, ROOT);
        issue(1'b1, `MBOX_EXECUTE_OFS, 32'd0, ROOT);
        idle();
        while (m_zbusy || m_lock) idle();
        issue(1'b0, `MBOX_LOCK_OFS, 32'd0, USER_A);
        issue(1'b0, `MBOX_LOCK_OFS, 32'd0, USER_A);
        issue(1'b0, `MBOX_USER_OFS, 32'd0, USER_B);
        acquire(ROOT);
        issue(1'b0, `MBOX_LOCK_OFS, 32'd0, USER_B);
        idle();

        // Holder writes and reads back, others get nothing
        test_name = "sram_access";
        acquire(USER_A);
        for (int n = 0; n < 150; n++) begin
            k = {$random(seed)} % 4;
            a = (k == 0) ? 16'h2000 + (16'($random(seed)) & 16'h0FFC)
                         : 16'h1000 + (16'($random(seed)) & 16'h0FFC);
            issue(1'b1, a, $random(seed), (k == 1) ? USER_B : USER_A);
            issue(1'b0, a, 32'd0, (k == 1) ? USER_B : USER_A);
        end
        idle();

        // SoC execute, release and partial zeroing
        test_name = "zeroize";
        acquire(USER_C);
        issue(1'b1, `MBOX_DLEN_OFS, 32'd16 + ($random(seed) & 32'hF0), USER_C);
        issue(1'b1, `MBOX_EXECUTE_OFS, 32'd1, USER_C);
        idle();
        @(negedge clk);
        check("soc_data_available", 32'd1, 32'(soc_data_available));
        for (int i = 0; i < 80; i++) begin
            issue(1'b1, 16'h1000 + 16'(i * 4), $random(seed), USER_C);
        end
        issue(1'b1, `MBOX_EXECUTE_OFS, 32'd0, USER_C);
        idle();
        while (m_zbusy || m_lock) idle();
        acquire(USER_C);
        for (int i = 0; i < 80; i++) begin
            issue(1'b0, 16'h1000 + 16'(i * 4), 32'd0, USER_C);
        end
        idle();
        idle();
        // Whole memory against the shadow copy
        for (int i = 0; i < 1024; i++) begin
            check("sram_contents", shadow[i], sram_mem[i]);
        end

        if (err_cnt == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("tests failed");
            $fatal(1, "errors found");
        end
    end

endmodule

//--- vlog.f
+incdir+logic
logic/mcu_mbox_bus_pkg.sv
logic/mcu_mbox_ctrl_pkg.sv
logic/mcu_mbox_user_check.sv
logic/mcu_mbox_zeroizer.sv
logic/mcu_mbox_ctrl.sv
logic/mcu_mbox_top.sv
dv/mcu_mbox_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the mailbox testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module mcu_mbox_tb -o mcu_mbox_sim

out=$(./obj_dir/mcu_mbox_sim)
echo "$out"

# Pass only when the testbench printed its pass line
echo "$out" | grep -qx "all tests passed"
